/* src.f */
verilog/bus_pkg.sv
verilog/bus_strobe_sync.sv
verilog/mem_mapper.sv
verilog/io_regs.sv
verilog/host_master.sv
verilog/bus_arbiter.sv
verilog/aq_bus_top.sv
test/aq_bus_model.sv
test/aq_bus_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module aq_bus_tb -f src.f -o aq_bus_sim &&
obj_dir/aq_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Done: no errors" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

/* test/aq_bus_tb.sv */
module aq_bus_tb import bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int          clk_half       = 50;
    localparam int          timeout_cycles = 500;
    localparam logic [31:0] seed_init      = 32'he8cd_8331;

    localparam logic [7:0] host_ports [8] = '{
        8'hF0, 8'hF1, 8'hF2, 8'hF3, 8'hFC, 8'hFD, 8'hFE, 8'hFF
    };

    logic        sysclk;
    logic        reset;
    bus_req_t    cpu_bus;
    logic        busack_n;
    logic        host_req;
    host_cmd_t   host_cmd;
    logic [63:0] keys;
    logic        cassette_in;
    logic        printer_in;
    logic        vblank;
    logic [7:0]  cpu_rdata;
    logic        cpu_rdata_oe;
    logic        busreq_n;
    logic        rom_ce_n;
    logic        ram_ce_n;
    logic [4:0]  bank_addr;
    logic        host_ack;
    logic [7:0]  host_rdata;
    logic        cassette_out;
    logic        printer_out;
    logic        cpm_remap;

    logic [7:0]  exp_cpu_rdata;
    logic [7:0]  exp_host_rdata;
    logic        exp_rom_ce_n;
    logic        exp_ram_ce_n;
    logic [4:0]  exp_bank_addr;
    logic        exp_cassette_out;
    logic        exp_printer_out;
    logic        exp_cpm_remap;

    // Seen mid strobe of the last CPU cycle and at the last host ack
    logic [7:0]  got_rdata;
    logic        got_oe;
    logic [7:0]  want_rdata;
    logic [7:0]  got_host;
    logic [7:0]  want_host;
    integer      seed = seed_init;

    aq_bus_top aq_bus_top_i (.*);

    aq_bus_model #(
        .SEED(seed_init)
    ) model_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #(clk_half) sysclk = ~sysclk;
    end

    ////////////////////
    // Checking

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
            abort_run($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic logic [31:0] rand_word();
        return 32'($random(seed));
    endfunction

    // Bus request only while the host handshake is open
    always @(negedge sysclk) begin
        if (!reset && !host_req && !host_ack)
            check("busreq_n without a host request", 1, busreq_n);
    end

    ////////////////////
    // Bus cycles

    task automatic cpu_cycle(input string name, input logic is_io, input logic write,
                             input logic [15:0] addr, input logic [7:0] wdata);
        bus_req_t req;
        int       n;
        n = 0;
        while (busack_n !== 1'b1 && n < timeout_cycles) begin
            @(negedge sysclk);
            n++;
        end
        if (busack_n !== 1'b1)
            abort_run({name, ": CPU never got the bus back from the host master"});
        req.addr   = addr;
        req.wdata  = wdata;
        req.rd_n   = write;
        req.wr_n   = !write;
        req.mreq_n = is_io;
        req.iorq_n = !is_io;
        @(posedge sysclk);
        cpu_bus <= req;
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        got_rdata  = cpu_rdata;
        got_oe     = cpu_rdata_oe;
        want_rdata = exp_cpu_rdata;
        check({name, " rom_ce_n"}, exp_rom_ce_n, rom_ce_n);
        check({name, " ram_ce_n"}, exp_ram_ce_n, ram_ce_n);
        if (!is_io)
            check({name, " bank_addr"}, exp_bank_addr, bank_addr);
        repeat (3) @(posedge sysclk);   // Strobe held 5 cycles
        cpu_bus <= bus_idle;
        @(negedge sysclk);
    endtask

    task automatic cpu_io_read(input string name, input logic [15:0] addr);
        cpu_cycle(name, 1'b1, 1'b0, addr, 8'h00);
        check({name, " cpu_rdata_oe"}, 1, got_oe);
    endtask

    task automatic host_transfer(input string name, input logic is_io, input logic write,
                                 input logic [15:0] addr, input logic [7:0] wdata);
        host_cmd_t cmd;
        int        n;
        cmd.is_io = is_io;
        cmd.write = write;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        @(posedge sysclk);
        host_cmd <= cmd;
        host_req <= 1'b1;
        n = 0;
        @(negedge sysclk);
        while (host_ack !== 1'b1 && n < timeout_cycles) begin
            @(negedge sysclk);
            n++;
        end
        if (host_ack !== 1'b1)
            abort_run({name, ": host master never acknowledged the request"});
        got_host  = host_rdata;
        want_host = exp_host_rdata;
        @(posedge sysclk);
        host_req <= 1'b0;
        n = 0;
        @(negedge sysclk);
        while (host_ack !== 1'b0 && n < timeout_cycles) begin
            @(negedge sysclk);
            n++;
        end
        if (host_ack !== 1'b0)
            abort_run({name, ": host_ack stayed high after the request dropped"});
    endtask

    ////////////////////
    // Test sequence

    initial begin
        logic [7:0]  val;
        logic [7:0]  port;
        logic [15:0] addr;
        reset       = 1'b1;
        cpu_bus     = bus_idle;
        host_req    = 1'b0;
        host_cmd    = '0;
        keys        = '1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        vblank      = 1'b0;
        repeat (8) @(posedge sysclk);
        reset <= 1'b0;
        @(negedge sysclk);

        // Reset defaults
        check("cassette_out after reset", 0, cassette_out);
        check("printer_out after reset", 0, printer_out);
        check("cpm_remap after reset", 0, cpm_remap);
        cpu_io_read("bank0 reset", 16'h00F0);
        check("bank0 reset", 8'hC0, got_rdata);
        cpu_io_read("bank1 reset", 16'h00F1);
        check("bank1 reset", 8'h21, got_rdata);
        cpu_io_read("bank2 reset", 16'h00F2);
        check("bank2 reset", 8'h22, got_rdata);
        cpu_io_read("bank3 reset", 16'h00F3);
        check("bank3 reset", 8'h13, got_rdata);

        // Bank registers with a random high address byte
        for (int i = 0; i < 24; i++) begin
            val  = rand_byte();
            port = {6'b111100, val[1:0]};
            val  = rand_byte();
            cpu_cycle("bank write", 1'b1, 1'b1, {rand_byte(), port}, val);
            cpu_io_read("bank read", {rand_byte(), port});
            check("bank round trip", val, got_rdata);
        end

        // Memory map with fresh bank contents now and then
        for (int i = 0; i < 48; i++) begin
            if (i % 3 == 0) begin
                val  = rand_byte();
                port = {6'b111100, val[1:0]};
                cpu_cycle("bank setup", 1'b1, 1'b1, {8'h00, port}, rand_byte());
            end
            addr = {rand_byte(), rand_byte()};
            if (i % 4 == 1)
                addr[13:11] = 3'b111;   // Overlay window
            val = rand_byte();
            cpu_cycle("memory map", 1'b0, val[0], addr, rand_byte());
            check("memory cycle cpu_rdata_oe", 0, got_oe);
        end

        // Single bit ports
        for (int i = 0; i < 8; i++) begin
            val = rand_byte();
            cpu_cycle("cassette write", 1'b1, 1'b1, 16'h00FC, val);
            check("cassette_out", val[0], cassette_out);
            val = rand_byte();
            cpu_cycle("printer write", 1'b1, 1'b1, 16'h00FE, val);
            check("printer_out", val[0], printer_out);
            val = rand_byte();
            cpu_cycle("cpm remap write", 1'b1, 1'b1, 16'h00FD, val);
            check("cpm_remap", val[0], cpm_remap);
            @(posedge sysclk);
            val = rand_byte();
            cassette_in <= val[0];
            printer_in  <= val[1];
            vblank      <= val[2];
            cpu_io_read("cassette in", {rand_byte(), 8'hFC});
            check("cassette in", want_rdata, got_rdata);
            cpu_io_read("vblank status", {rand_byte(), 8'hFD});
            check("vblank status", want_rdata, got_rdata);
            cpu_io_read("printer in", {rand_byte(), 8'hFE});
            check("printer in", want_rdata, got_rdata);
        end

        // Keyboard rows picked by address bits 15-8
        for (int i = 0; i < 16; i++) begin
            @(posedge sysclk);
            keys <= {rand_word(), rand_word()};
            cpu_io_read("keyboard", {rand_byte(), 8'hFF});
            check("keyboard", want_rdata, got_rdata);
        end

        // Host and CPU see the same registers
        val = rand_byte();
        host_transfer("host bank write", 1'b1, 1'b1, 16'h00F2, val);
        cpu_io_read("cpu read of host write", 16'h00F2);
        check("cpu read of host write", val, got_rdata);
        val = rand_byte();
        cpu_cycle("cpu bank write", 1'b1, 1'b1, 16'h00F1, val);
        host_transfer("host read of cpu write", 1'b1, 1'b0, 16'h00F1, 8'h00);
        check("host read of cpu write", val, got_host);

        for (int i = 0; i < 24; i++) begin
            val  = rand_byte();
            port = host_ports[val[2:0]];
            if (val[7]) begin
                host_transfer("host write", 1'b1, 1'b1, {rand_byte(), port}, rand_byte());
                check("host write cassette_out", exp_cassette_out, cassette_out);
                check("host write printer_out", exp_printer_out, printer_out);
                check("host write cpm_remap", exp_cpm_remap, cpm_remap);
            end else begin
                host_transfer("host read", 1'b1, 1'b0, {rand_byte(), port}, 8'h00);
                check("host read", want_host, got_host);
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

/* test/aq_bus_model.sv */
module aq_bus_model import bus_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0
) (
    input  logic        sysclk,
    input  logic        reset,
    input  bus_req_t    cpu_bus,
    input  logic        host_req,
    input  host_cmd_t   host_cmd,
    input  logic        host_ack,
    input  logic        busreq_n,
    input  logic [63:0] keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        vblank,
    output logic        busack_n,
    output logic [7:0]  exp_cpu_rdata,
    output logic [7:0]  exp_host_rdata,
    output logic        exp_rom_ce_n,
    output logic        exp_ram_ce_n,
    output logic [4:0]  exp_bank_addr,
    output logic        exp_cassette_out,
    output logic        exp_printer_out,
    output logic        exp_cpm_remap
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [7:0] bank_m [4];
    logic       wr_en;
    logic [7:0] wr_port;
    logic [7:0] wr_val;
    logic [7:0] sel_bank;
    logic [5:0] page;
    integer     ack_seed = SEED;
    logic [1:0] ack_wait;
    logic       ack_armed;

    ////////////////////
    // Register shadow

    // IO write from whichever side owns the bus
    always_comb begin
        wr_en   = 1'b0;
        wr_port = cpu_bus.addr[7:0];
        wr_val  = cpu_bus.wdata;
        if (!cpu_bus.wr_n && !cpu_bus.iorq_n) begin
            wr_en = 1'b1;
        end else if (host_req && host_ack && host_cmd.write && host_cmd.is_io) begin
            wr_en   = 1'b1;
            wr_port = host_cmd.addr[7:0];
            wr_val  = host_cmd.wdata;
        end
    end

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_m[0]        <= 8'hC0;  // Page 0, overlay, read-only
            bank_m[1]        <= 8'h21;
            bank_m[2]        <= 8'h22;
            bank_m[3]        <= 8'h13;
            exp_cassette_out <= 1'b0;
            exp_printer_out  <= 1'b0;
            exp_cpm_remap    <= 1'b0;
        end else if (wr_en) begin
            case (wr_port)
                8'hF0, 8'hF1, 8'hF2, 8'hF3: bank_m[wr_port[1:0]] <= wr_val;
                8'hFC: exp_cassette_out <= wr_val[0];
                8'hFD: exp_cpm_remap    <= wr_val[0];
                8'hFE: exp_printer_out  <= wr_val[0];
                default: ;
            endcase
        end
    end

    // What an IO read of this address should return
    function automatic logic [7:0] port_read(input logic [15:0] addr);
        logic [7:0] rows;
        rows = 8'hFF;
        case (addr[7:0])
            8'hF0, 8'hF1, 8'hF2, 8'hF3: return bank_m[addr[1:0]];
            8'hFC: return {7'd0, cassette_in};
            8'hFD: return {7'd0, ~vblank};
            8'hFE: return {7'd0, printer_in};
            8'hFF: begin
                for (int r = 0; r < 8; r++) begin
                    if (addr[8 + r] == 1'b0)
                        rows = rows & keys[8 * r +: 8];
                end
                return rows;
            end
            default: return 8'h00;
        endcase
    endfunction

    always_comb begin
        exp_cpu_rdata  = port_read(cpu_bus.addr);
        exp_host_rdata = port_read(host_cmd.addr);
    end

    ////////////////////
    // Memory map

    always_comb begin
        sel_bank      = bank_m[cpu_bus.addr[15:14]];
        page          = sel_bank[5:0];
        exp_rom_ce_n  = 1'b1;
        exp_ram_ce_n  = 1'b1;
        exp_bank_addr = page[4:0];
        if (!cpu_bus.mreq_n) begin
            if (sel_bank[6] && cpu_bus.addr[13:11] == 3'b111) begin
                exp_ram_ce_n  = 1'b0;   // Overlay at $3800-$3FFF of the window
                exp_bank_addr = 5'd0;
            end else if (!(sel_bank[7] && !cpu_bus.wr_n)) begin
                if (page < 6'd16)
                    exp_rom_ce_n = 1'b0;
                else if (page >= 6'd32)
                    exp_ram_ce_n = 1'b0;
            end
        end
    end

    ////////////////////
    // CPU bus acknowledge

    // Answers busreq_n after 0 to 3 extra cycles
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            busack_n  <= 1'b1;
            ack_armed <= 1'b0;
            ack_wait  <= 2'd0;
        end else if (busreq_n) begin
            busack_n  <= 1'b1;
            ack_armed <= 1'b0;
        end else if (busack_n) begin
            if (!ack_armed) begin
                ack_wait  <= 2'($random(ack_seed));
                ack_armed <= 1'b1;
            end else if (ack_wait == 2'd0) begin
                busack_n <= 1'b0;
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end
    end

endmodule

/* verilog/aq_bus_top.sv */
module aq_bus_top import bus_pkg::*; #(
    parameter int SYNC_STAGES        = 3,
    parameter int HOST_STROBE_CYCLES = 6
) (
    input  logic        sysclk,
    input  logic        reset,
    input  bus_req_t    cpu_bus,
    input  logic        busack_n,
    input  logic        host_req,
    input  host_cmd_t   host_cmd,
    input  logic [63:0] keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        vblank,
    output logic [7:0]  cpu_rdata,
    output logic        cpu_rdata_oe,
    output logic        busreq_n,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic [4:0]  bank_addr,
    output logic        host_ack,
    output logic [7:0]  host_rdata,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        cpm_remap
);

    bus_req_t        host_bus;
    bus_req_t        sys_bus;
    logic            bus_want;
    logic            grant;
    logic            bus_write;
    logic [7:0]      wrdata;
    logic [7:0]      rd_data;
    bank_reg_u [3:0] banks;
    mem_sel_t        mem_sel;

    ////////////////////
    // Bus owners

    host_master #(
        .HOST_STROBE_CYCLES(HOST_STROBE_CYCLES)
    ) host_master_i (
        .sysclk    (sysclk),
        .reset     (reset),
        .host_req  (host_req),
        .host_cmd  (host_cmd),
        .grant     (grant),
        .rd_data   (rd_data),
        .host_ack  (host_ack),
        .host_rdata(host_rdata),
        .bus_want  (bus_want),
        .host_bus  (host_bus)
    );

    bus_arbiter bus_arbiter_i (
        .sysclk  (sysclk),
        .reset   (reset),
        .bus_want(bus_want),
        .busack_n(busack_n),
        .cpu_bus (cpu_bus),
        .host_bus(host_bus),
        .grant   (grant),
        .busreq_n(busreq_n),
        .sys_bus (sys_bus)
    );

    ////////////////////
    // Decode and registers

    bus_strobe_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) bus_strobe_sync_i (
        .sysclk   (sysclk),
        .reset    (reset),
        .sys_bus  (sys_bus),
        .bus_read (),               // No read side effects left
        .bus_write(bus_write),
        .wrdata   (wrdata)
    );

    mem_mapper mem_mapper_i (
        .sys_bus  (sys_bus),
        .banks    (banks),
        .mem_sel  (mem_sel),
        .rom_ce_n (rom_ce_n),
        .ram_ce_n (ram_ce_n),
        .bank_addr(bank_addr)
    );

    io_regs io_regs_i (
        .sysclk      (sysclk),
        .reset       (reset),
        .sys_bus     (sys_bus),
        .bus_write   (bus_write),
        .wrdata      (wrdata),
        .keys        (keys),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .vblank      (vblank),
        .banks       (banks),
        .rd_data     (rd_data),
        .cassette_out(cassette_out),
        .printer_out (printer_out),
        .cpm_remap   (cpm_remap)
    );

    // Data bus driven only for internal IO reads
    assign cpu_rdata    = rd_data;
    assign cpu_rdata_oe = !sys_bus.rd_n && mem_sel.io_internal;

endmodule

/* verilog/bus_arbiter.sv */
module bus_arbiter import bus_pkg::*; (
    input  logic     sysclk,
    input  logic     reset,
    input  logic     bus_want,
    input  logic     busack_n,
    input  bus_req_t cpu_bus,
    input  bus_req_t host_bus,
    output logic     grant,
    output logic     busreq_n,
    output bus_req_t sys_bus
);

    logic grant_d1;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            busreq_n <= 1'b1;
            grant    <= 1'b0;
            grant_d1 <= 1'b0;
        end else begin
            busreq_n <= !bus_want;
            grant    <= bus_want && !busack_n;  // CPU has let go of the bus
            grant_d1 <= grant;
        end
    end

    // Idle for one cycle on every change of owner
    always_comb begin
        if (grant != grant_d1)
            sys_bus = bus_idle;
        else if (grant)
            sys_bus = host_bus;
        else
            sys_bus = cpu_bus;
    end

    // CPU must stay off the bus while it acknowledges
    assert property (@(posedge sysclk) disable iff (reset)
        grant |-> cpu_bus.rd_n && cpu_bus.wr_n && cpu_bus.mreq_n && cpu_bus.iorq_n)
        else $error("CPU strobe while host owns the bus");

endmodule

/* verilog/host_master.sv */
module host_master import bus_pkg::*; #(
    parameter int HOST_STROBE_CYCLES = 6
) (
    input  logic       sysclk,
    input  logic       reset,
    input  logic       host_req,
    input  host_cmd_t  host_cmd,
    input  logic       grant,
    input  logic [7:0] rd_data,
    output logic       host_ack,
    output logic [7:0] host_rdata,
    output logic       bus_want,
    output bus_req_t   host_bus
);

    localparam int cnt_w = $clog2(HOST_STROBE_CYCLES + 1);

    typedef enum logic [2:0] {
        s_idle,
        s_want,         // Waiting for the grant
        s_strobe,
        s_done,         // Strobes released
        s_release       // Ack high until req drops
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] strobe_cnt;
    logic             strobe_last;
    logic             strobing;

    assign strobe_last = strobe_cnt == cnt_w'(HOST_STROBE_CYCLES - 1);

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            state      <= s_idle;
            strobe_cnt <= '0;
        end else begin
            case (state)
                s_idle: if (host_req) state <= s_want;
                s_want: begin
                    if (grant) begin
                        state      <= s_strobe;
                        strobe_cnt <= '0;
                    end
                end
                s_strobe: begin
                    if (strobe_last)
                        state <= s_done;
                    else
                        strobe_cnt <= strobe_cnt + 1'b1;
                end
                s_done:    state <= s_release;
                s_release: if (!host_req) state <= s_idle;
                default:   state <= s_idle;
            endcase
        end
    end

    // Sample in the last strobe cycle
    always_ff @(posedge sysclk) begin
        if (state == s_strobe && strobe_last && !host_cmd.write)
            host_rdata <= rd_data;
    end

    assign bus_want = state inside {s_want, s_strobe, s_done};
    assign host_ack = state == s_release;
    assign strobing = state == s_strobe;

    assign host_bus.addr   = host_cmd.addr;
    assign host_bus.wdata  = host_cmd.wdata;
    assign host_bus.rd_n   = !(strobing && !host_cmd.write);
    assign host_bus.wr_n   = !(strobing && host_cmd.write);
    assign host_bus.mreq_n = !(strobing && !host_cmd.is_io);
    assign host_bus.iorq_n = !(strobing && host_cmd.is_io);

    // Host side of the handshake keeps the command until acked
    assert property (@(posedge sysclk) disable iff (reset)
        host_req && !host_ack |=> !host_req || $stable(host_cmd))
        else $error("host_cmd changed during a pending request");

endmodule

/* verilog/io_regs.sv */
module io_regs import bus_pkg::*; (
    input  logic            sysclk,
    input  logic            reset,
    input  bus_req_t        sys_bus,
    input  logic            bus_write,
    input  logic [7:0]      wrdata,
    input  logic [63:0]     keys,
    input  logic            cassette_in,
    input  logic            printer_in,
    input  logic            vblank,
    output bank_reg_u [3:0] banks,
    output logic [7:0]      rd_data,
    output logic            cassette_out,
    output logic            printer_out,
    output logic            cpm_remap
);

    logic [7:0] port;
    logic       io_write;
    logic [7:0] keyb_data;

    assign port     = sys_bus.addr[7:0];
    assign io_write = bus_write && !sys_bus.iorq_n;

    ////////////////////
    // Register writes

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks          <= bank_reset;
            cassette_out   <= 1'b0;
            printer_out    <= 1'b0;
            cpm_remap      <= 1'b0;
        end else if (io_write) begin
            case (port)
                io_bank0, io_bank1, io_bank2, io_bank3: begin
                    banks[port[1:0]].raw <= wrdata;
                end
                io_cassette: cassette_out   <= wrdata[0];
                io_sys:      cpm_remap      <= wrdata[0];
                io_printer:  printer_out    <= wrdata[0];
                default: ;  // Scramble write at $FF goes nowhere without a cartridge
            endcase
        end
    end

    ////////////////////
    // Keyboard matrix

    // AND of the rows whose address line is low
    always_comb begin
        keyb_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!sys_bus.addr[8 + row])
                keyb_data &= keys[row * 8 +: 8];
        end
    end

    ////////////////////
    // Read data

    always_comb begin
        rd_data = 8'h00;
        if (!sys_bus.iorq_n) begin
            case (port)
                io_bank0, io_bank1, io_bank2, io_bank3: begin
                    rd_data = banks[port[1:0]].raw;
                end
                io_cassette: rd_data = {7'b0, cassette_in};
                io_sys:      rd_data = {7'b0, !vblank};    // High outside vblank
                io_printer:  rd_data = {7'b0, printer_in};
                io_keyb:     rd_data = keyb_data;
                default:     rd_data = 8'h00;
            endcase
        end
    end

endmodule

/* verilog/mem_mapper.sv */
module mem_mapper import bus_pkg::*; (
    input  bus_req_t        sys_bus,
    input  bank_reg_u [3:0] banks,
    output mem_sel_t        mem_sel,
    output logic            rom_ce_n,
    output logic            ram_ce_n,
    output logic [4:0]      bank_addr
);

    bank_reg_u sel_bank;
    logic      io_known;
    logic      write_blocked;
    logic      allow_mem;

    assign sel_bank = banks[sys_bus.addr[15:14]];   // 16KB windows

    ////////////////////
    // Decode

    assign io_known = sys_bus.addr[7:0] inside {
        io_bank0, io_bank1, io_bank2, io_bank3,
        io_cassette, io_sys, io_printer, io_keyb
    };

    assign mem_sel.io_internal = !sys_bus.iorq_n && io_known;

    // $3800-$3FFF of the window when overlay is on
    assign mem_sel.sysram = !sys_bus.mreq_n && sel_bank.f.overlay &&
                            sys_bus.addr[13:11] == 3'b111;

    assign write_blocked = !sys_bus.wr_n && sel_bank.f.ro;

    assign allow_mem = !sys_bus.mreq_n && !mem_sel.io_internal &&
                       !mem_sel.sysram && !write_blocked;

    assign mem_sel.rom = allow_mem && sel_bank.f.page[5:4] == 2'b00;        // Page 0-15
    assign mem_sel.ram = (allow_mem && sel_bank.f.page[5]) || mem_sel.sysram; // Page 32-63

    ////////////////////
    // Outputs

    assign rom_ce_n  = !mem_sel.rom;
    assign ram_ce_n  = !mem_sel.ram;
    assign bank_addr = mem_sel.sysram ? 5'd0 : sel_bank.f.page[4:0];   // System RAM is page 32

endmodule

/* verilog/bus_strobe_sync.sv */
module bus_strobe_sync import bus_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  logic       sysclk,
    input  logic       reset,
    input  bus_req_t   sys_bus,
    output logic       bus_read,
    output logic       bus_write,
    output logic [7:0] wrdata
);

    logic [SYNC_STAGES-1:0] rd_n_sr;
    logic [SYNC_STAGES-1:0] wr_n_sr;

    // Strobe history, idle high
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_n_sr <= '1;
            wr_n_sr <= '1;
        end else begin
            rd_n_sr <= {rd_n_sr[SYNC_STAGES-2:0], sys_bus.rd_n};
            wr_n_sr <= {wr_n_sr[SYNC_STAGES-2:0], sys_bus.wr_n};
        end
    end

    // Falling edge seen between the last two stages
    assign bus_read  = rd_n_sr[SYNC_STAGES-1] && !rd_n_sr[SYNC_STAGES-2];
    assign bus_write = wr_n_sr[SYNC_STAGES-1] && !wr_n_sr[SYNC_STAGES-2];

    always_ff @(posedge sysclk) begin
        if (!sys_bus.wr_n)
            wrdata <= sys_bus.wdata;    // Stable by the time bus_write fires
    end

    // Bus owners never overlap rd and wr, so neither may the pulses
    assert property (@(posedge sysclk) disable iff (reset) !(bus_read && bus_write))
        else $error("bus_read and bus_write pulsed together");

endmodule

/* verilog/bus_pkg.sv */
package bus_pkg;

    ////////////////////
    // Bus types

    // One cycle on the shared Z80 bus
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd_n;
        logic        wr_n;
        logic        mreq_n;
        logic        iorq_n;
    } bus_req_t;

    typedef struct packed {
        logic        is_io;    // IO cycle instead of memory
        logic        write;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } host_cmd_t;

    typedef struct packed {
        logic       ro;        // Writes blocked
        logic       overlay;   // System RAM at $3800-$3FFF
        logic [5:0] page;
    } bank_fields_t;

    // Bank register, raw byte on the IO side, fields on the mapping side
    typedef union packed {
        logic [7:0]   raw;
        bank_fields_t f;
    } bank_reg_u;

    typedef struct packed {
        logic rom;
        logic ram;
        logic sysram;
        logic io_internal;
    } mem_sel_t;

    ////////////////////
    // IO ports

    localparam logic [7:0] io_bank0    = 8'hF0;
    localparam logic [7:0] io_bank1    = 8'hF1;
    localparam logic [7:0] io_bank2    = 8'hF2;
    localparam logic [7:0] io_bank3    = 8'hF3;
    localparam logic [7:0] io_cassette = 8'hFC;
    localparam logic [7:0] io_sys      = 8'hFD;  // R: vblank, W: CP/M remap
    localparam logic [7:0] io_printer  = 8'hFE;
    localparam logic [7:0] io_keyb     = 8'hFF;  // R: keyboard, W: scramble

    // Index 0 is bank 0: page 0 with overlay and RO, then pages 33, 34, 19
    localparam bank_reg_u [3:0] bank_reset = {8'h13, 8'h22, 8'h21, 8'hC0};

    localparam bus_req_t bus_idle = '{
        addr:   16'h0000,
        wdata:  8'h00,
        rd_n:   1'b1,
        wr_n:   1'b1,
        mreq_n: 1'b1,
        iorq_n: 1'b1
    };

endpackage
